//--- design/rv_pkg.sv
// RV32I core definitions
package rv_pkg;

	// Major opcodes, instr[6:0]
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

	// ALU operation select
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_xor,
		alu_or,
		alu_and
	} alu_op_e;

	// Shared by branches and set-less-than
	typedef enum logic [1:0] {
		cmp_eq,
		cmp_lt,
		cmp_ltu
	} compare_op_e;

	// Sequencing states
	typedef enum logic [2:0] {
		state_fetch,
		state_decode,
		state_execute,
		state_mem_read,
		state_mem_write
	} core_state_e;

	// Matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_e;

endpackage

//--- design/rv_decoder.sv
// RV32I instruction decoder
`timescale 1ns/1ps

module rv_decoder (
	input  logic [31:0]         instr,
	output logic                op_load,
	output logic                op_store,
	output logic                op_op_imm,
	output logic                op_op,
	output logic                op_branch,
	output logic                op_jal,
	output logic                op_jalr,
	output logic                op_lui,
	output logic                op_auipc,
	output logic [4:0]          rs1,
	output logic [4:0]          rs2,
	output logic [4:0]          rd,
	output logic [31:0]         imm,
	output rv_pkg::alu_op_e     alu_op,
	output rv_pkg::compare_op_e compare_op,
	output rv_pkg::mem_size_e   size,
	output logic                load_unsigned,
	output logic                branch_invert,
	output logic                slt_result
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_5;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7_5 = instr[30];    // SUB and SRA select

	assign op_load   = (opcode == opc_load);
	assign op_store  = (opcode == opc_store);
	assign op_op_imm = (opcode == opc_op_imm);
	assign op_op     = (opcode == opc_op);
	assign op_branch = (opcode == opc_branch);
	assign op_jal    = (opcode == opc_jal);
	assign op_jalr   = (opcode == opc_jalr);
	assign op_lui    = (opcode == opc_lui);
	assign op_auipc  = (opcode == opc_auipc);

	// Register fields never move
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// One immediate, shaped by instruction class
	always_comb begin
		if (op_store) begin
			imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		end else if (op_branch) begin
			imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
		end else if (op_lui || op_auipc) begin
			imm = {instr[31:12], 12'h000};
		end else if (op_jal) begin
			imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		end else begin
			imm = {{20{instr[31]}}, instr[31:20]}; // I form
		end
	end

	always_comb begin
		alu_op = alu_add; // Addresses, targets, LUI and AUIPC
		if (op_op || op_op_imm) begin
			case (funct3)
				3'b000: alu_op = (op_op && funct7_5) ? alu_sub : alu_add;
				3'b001: alu_op = alu_sll;
				3'b100: alu_op = alu_xor;
				3'b101: alu_op = funct7_5 ? alu_sra : alu_srl;
				3'b110: alu_op = alu_or;
				3'b111: alu_op = alu_and;
				default: alu_op = alu_add; // SLT forms go through the comparator
			endcase
		end
	end

	always_comb begin
		if (op_op || op_op_imm) begin
			compare_op = funct3[0] ? cmp_ltu : cmp_lt;
		end else begin
			case (funct3[2:1])
				2'b10: compare_op = cmp_lt;   // BLT, BGE
				2'b11: compare_op = cmp_ltu;  // BLTU, BGEU
				default: compare_op = cmp_eq; // BEQ, BNE
			endcase
		end
	end

	// SLT, SLTU, SLTI, SLTIU
	assign slt_result = (op_op || op_op_imm) && (funct3[2:1] == 2'b01);

	assign branch_invert = funct3[0]; // BNE, BGE, BGEU
	assign size          = mem_size_e'(funct3[1:0]);
	assign load_unsigned = funct3[2];

endmodule

//--- design/rv_alu.sv
// Integer ALU
`timescale 1ns/1ps

module rv_alu (
	input  logic [31:0]     op_a,
	input  logic [31:0]     op_b,
	input  rv_pkg::alu_op_e op,
	output logic [31:0]     result
);
	import rv_pkg::*;

	logic [4:0] shamt;

	assign shamt = op_b[4:0]; // Only the low five bits shift

	always_comb begin
		case (op)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_sll: result = op_a << shamt;
			alu_srl: result = op_a >> shamt;
			alu_sra: result = $unsigned($signed(op_a) >>> shamt);
			alu_xor: result = op_a ^ op_b;
			alu_or:  result = op_a | op_b;
			alu_and: result = op_a & op_b;
			default: result = op_a + op_b;
		endcase
	end

endmodule

//--- design/rv_comparator.sv
// Branch and set-less-than comparator
`timescale 1ns/1ps

module rv_comparator (
	input  logic [31:0]         in_a,
	input  logic [31:0]         in_b,
	input  rv_pkg::compare_op_e op,
	output logic                result
);
	import rv_pkg::*;

	always_comb begin
		case (op)
			cmp_lt:  result = ($signed(in_a) < $signed(in_b));
			cmp_ltu: result = (in_a < in_b);
			default: result = (in_a == in_b);
		endcase
	end

endmodule

//--- design/rv_regfile.sv
// Integer register file
`timescale 1ns/1ps

module rv_regfile (
	input  logic        clock,
	input  logic        reset,
	input  logic [4:0]  ra_addr,
	input  logic [4:0]  rb_addr,
	output logic [31:0] ra_data,
	output logic [31:0] rb_data,
	input  logic [4:0]  rd_addr,
	input  logic [31:0] rd_data,
	input  logic        rd_write
);

	logic [31:0] regs [32];

	// Reads are combinational
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_write && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= rd_data; // x0 never written
		end
	end

endmodule

//--- design/rv_load_store.sv
// Load and store lane handling
`timescale 1ns/1ps

module rv_load_store (
	input  logic [1:0]        addr_low,
	input  rv_pkg::mem_size_e size,
	input  logic              load_unsigned,
	input  logic [31:0]       store_data,
	input  logic [31:0]       bus_rdata,
	output logic [31:0]       bus_wdata,
	output logic [3:0]        bus_strobe,
	output logic [31:0]       load_value
);
	import rv_pkg::*;

	logic [7:0]  load_byte;
	logic [15:0] load_half;

	// Store data copied to every lane, strobes pick the live ones
	always_comb begin
		case (size)
			size_byte: begin
				bus_wdata  = {4{store_data[7:0]}};
				bus_strobe = 4'b0001 << addr_low;
			end
			size_half: begin
				bus_wdata  = {2{store_data[15:0]}};
				bus_strobe = addr_low[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				bus_wdata  = store_data;
				bus_strobe = 4'b1111;
			end
		endcase
	end

	always_comb begin
		case (addr_low)
			2'b00: load_byte = bus_rdata[7:0];
			2'b01: load_byte = bus_rdata[15:8];
			2'b10: load_byte = bus_rdata[23:16];
			default: load_byte = bus_rdata[31:24];
		endcase
	end

	assign load_half = addr_low[1] ? bus_rdata[31:16] : bus_rdata[15:0];

	always_comb begin
		case (size)
			size_byte: load_value = {{24{load_byte[7] & ~load_unsigned}}, load_byte};
			size_half: load_value = {{16{load_half[15] & ~load_unsigned}}, load_half};
			default:   load_value = bus_rdata;
		endcase
	end

endmodule

//--- design/rv_core.sv
// Multi-cycle RV32I core
`timescale 1ns/1ps

module rv_core #(
	parameter logic [31:0] reset_addr = 32'h0000_0000
) (
	input  logic        clock,
	input  logic        reset,
	output logic [31:0] iaddr,
	input  logic [31:0] idata,
	output logic        ivalid,
	input  logic        iready,
	output logic [31:0] daddr,
	output logic [31:0] dwdata,
	input  logic [31:0] drdata,
	output logic [3:0]  dstrb,
	output logic        dwrite,
	output logic        dvalid,
	input  logic        dready
);
	import rv_pkg::*;

	core_state_e state;
	logic [31:0] instr;
	logic [31:2] pc;       // Word program counter
	logic [31:2] pc_plus4;
	logic [31:2] pc_next;

	logic        fetch_fire;
	logic        data_fire;

	logic        op_load;
	logic        op_store;
	logic        op_op_imm;
	logic        op_op;
	logic        op_branch;
	logic        op_jal;
	logic        op_jalr;
	logic        op_lui;
	logic        op_auipc;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;
	alu_op_e     alu_op;
	compare_op_e compare_op;
	mem_size_e   size;
	logic        load_unsigned;
	logic        branch_invert;
	logic        slt_result;

	logic [31:0] ra_data;
	logic [31:0] rb_data;
	logic [31:0] rd_data;
	logic        rd_write;
	logic        writes_rd;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic [31:0] cmp_b;
	logic        cmp_result;
	logic        branch_taken;
	logic [31:0] load_value;

	assign fetch_fire = ivalid && iready;
	assign data_fire  = dvalid && dready;
	assign pc_plus4   = pc + 30'd1;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_fetch;
			pc    <= reset_addr[31:2];
		end else begin
			case (state)
				state_fetch: begin
					if (fetch_fire) begin
						state <= state_decode;
					end
				end
				state_decode: state <= state_execute; // Decode settles
				state_execute: begin
					if (op_load) begin
						state <= state_mem_read;
					end else if (op_store) begin
						state <= state_mem_write;
					end else begin
						pc    <= pc_next;
						state <= state_fetch;
					end
				end
				state_mem_read, state_mem_write: begin
					if (data_fire) begin
						pc    <= pc_next;
						state <= state_fetch;
					end
				end
				default: state <= state_fetch;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_fire) begin
			instr <= idata;
		end
	end

	rv_decoder decoder_i (
		.instr         (instr),
		.op_load       (op_load),
		.op_store      (op_store),
		.op_op_imm     (op_op_imm),
		.op_op         (op_op),
		.op_branch     (op_branch),
		.op_jal        (op_jal),
		.op_jalr       (op_jalr),
		.op_lui        (op_lui),
		.op_auipc      (op_auipc),
		.rs1           (rs1),
		.rs2           (rs2),
		.rd            (rd),
		.imm           (imm),
		.alu_op        (alu_op),
		.compare_op    (compare_op),
		.size          (size),
		.load_unsigned (load_unsigned),
		.branch_invert (branch_invert),
		.slt_result    (slt_result)
	);

	rv_regfile regfile_i (
		.clock    (clock),
		.reset    (reset),
		.ra_addr  (rs1),
		.rb_addr  (rs2),
		.ra_data  (ra_data),
		.rb_data  (rb_data),
		.rd_addr  (rd),
		.rd_data  (rd_data),
		.rd_write (rd_write)
	);

	// Operand A is PC for PC-relative forms, zero for LUI
	always_comb begin
		if (op_auipc || op_jal || op_branch) begin
			alu_a = {pc, 2'b00};
		end else if (op_lui) begin
			alu_a = '0;
		end else begin
			alu_a = ra_data;
		end
	end

	assign alu_b = op_op ? rb_data : imm;

	rv_alu alu_i (
		.op_a   (alu_a),
		.op_b   (alu_b),
		.op     (alu_op),
		.result (alu_result)
	);

	assign cmp_b = op_op_imm ? imm : rb_data; // SLTI, SLTIU

	rv_comparator comparator_i (
		.in_a   (ra_data),
		.in_b   (cmp_b),
		.op     (compare_op),
		.result (cmp_result)
	);

	assign branch_taken = op_branch && (cmp_result ^ branch_invert);

	// ALU sum doubles as jump target and memory address
	assign pc_next = (op_jal || op_jalr || branch_taken) ? alu_result[31:2] : pc_plus4;

	rv_load_store load_store_i (
		.addr_low      (alu_result[1:0]),
		.size          (size),
		.load_unsigned (load_unsigned),
		.store_data    (rb_data),
		.bus_rdata     (drdata),
		.bus_wdata     (dwdata),
		.bus_strobe    (dstrb),
		.load_value    (load_value)
	);

	always_comb begin
		if (op_jal || op_jalr) begin
			rd_data = {pc_plus4, 2'b00}; // Link address
		end else if (op_load) begin
			rd_data = load_value;
		end else if (slt_result) begin
			rd_data = {31'd0, cmp_result};
		end else begin
			rd_data = alu_result;
		end
	end

	assign writes_rd = op_op || op_op_imm || op_lui || op_auipc || op_jal || op_jalr;

	// Loads write on the data transfer, others at the end of execute
	assign rd_write = (rd != 5'd0) &&
		(((state == state_execute) && writes_rd) ||
		((state == state_mem_read) && data_fire));

	// Fetch request held low through reset
	assign ivalid = (state == state_fetch) && !reset;
	assign iaddr  = {pc, 2'b00};

	assign dvalid = (state == state_mem_read) || (state == state_mem_write);
	assign dwrite = (state == state_mem_write);
	assign daddr  = {alu_result[31:2], 2'b00};

endmodule

//--- tb/rv_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module rv_clock_gen #(
	parameter int half_period  = 10,
	parameter int reset_cycles = 10
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	// Released on a rising edge, like any other driven input
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- tb/rv_core_tb.sv
// RV32I core random program testbench
`timescale 1ns/1ps

module rv_core_tb;
	import rv_pkg::*;

	localparam logic [31:0] reset_addr   = 32'h0000_0200;
	localparam logic [31:0] data_base    = 32'h0000_1000;
	localparam logic [31:0] seed         = 32'd5451;
	localparam int          program_len  = 200;
	localparam int          reset_cycles = 10;
	localparam int          clock_period = 20;
	localparam int          watchdog_cycles = program_len * (5 + 4 * 8) + reset_cycles;

	logic        clock;
	logic        reset;
	logic [31:0] iaddr;
	logic [31:0] idata;
	logic        ivalid;
	logic        iready;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [31:0] drdata;
	logic [3:0]  dstrb;
	logic        dwrite;
	logic        dvalid;
	logic        dready;

	logic [31:0] rng_state;
	logic [31:0] imem [256];
	logic [31:0] dmem [16];   // Bus side data memory
	logic [31:0] mdmem [16];  // Model data memory
	logic [31:0] mreg [32];

	logic [31:0] fetch_q [$];
	logic [31:0] exp_daddr [$];
	logic        exp_dwrite [$];
	logic [3:0]  exp_dstrb [$];
	logic [31:0] exp_dwdata [$];

	logic [31:0] expect_addr;
	logic [31:0] expect_data;
	logic [3:0]  expect_strb;
	logic        expect_write;
	logic        done;
	logic        run_started;
	int          checks;
	int          err_reset;
	int          err_fetch;
	int          err_data;
	int          nfetch;
	int          ndata;
	int          total;

	rv_clock_gen #(
		.half_period  (clock_period / 2),
		.reset_cycles (reset_cycles)
	) clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	rv_core #(
		.reset_addr (reset_addr)
	) rv_core_i (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dstrb  (dstrb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	// LCG, upper half only
	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	function automatic logic [31:0] rand_word();
		return {next_rand(), next_rand()};
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return {16'd0, next_rand()} % n;
	endfunction

	function automatic logic [4:0] pick_rd();
		return 5'(2 + rand_below(6)); // x1 keeps the data base
	endfunction

	function automatic logic [4:0] pick_rs();
		return 5'(rand_below(8));
	endfunction

	// Program word index of a fetch address
	function automatic logic [7:0] instr_index(input logic [31:0] addr);
		return 8'((addr - reset_addr) >> 2);
	endfunction

	function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic logic [31:0] btype_word(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
	endfunction

	function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jtype_word(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
	endfunction

	function automatic logic [3:0] data_index(input logic [31:0] addr);
		return 4'((addr - data_base) >> 2);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old & ~mask) | (data & mask);
	endfunction

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] load_extract(input logic [2:0] f3, input logic [1:0] lo,
			input logic [31:0] w);
		logic [31:0] sh;
		sh = w >> {lo, 3'b000};
		case (f3)
			3'd0: return {{24{sh[7]}}, sh[7:0]};
			3'd1: return {{16{sh[15]}}, sh[15:0]};
			3'd4: return {24'd0, sh[7:0]};
			3'd5: return {16'd0, sh[15:0]};
			default: return w;
		endcase
	endfunction

	task automatic build_program();
		int unsigned i;
		int unsigned kind;
		int unsigned target;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [5:0]  amask;
		logic [31:0] word;
		imem = '{default: 32'd0};
		imem[0] = utype_word(data_base[31:12], 5'd1, opc_lui);
		word = rand_word();
		imem[1] = utype_word(word[19:0], 5'd2, opc_lui);
		word = rand_word();
		imem[2] = utype_word(word[19:0], 5'd3, opc_lui);
		word = rand_word();
		imem[3] = utype_word(word[19:0], 5'd4, opc_lui);
		i = 4;
		while (i < program_len - 1) begin
			kind = rand_below(10);
			f3 = 3'(rand_below(8));
			word = rand_word();
			target = i + 1 + rand_below(4);
			if (target > program_len - 1) target = program_len - 1; // Forward only
			if (kind < 2) begin
				imm = {1'b0, word[0] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, pick_rs()};
				imem[8'(i)] = itype_word(imm, pick_rs(), f3, pick_rd(), opc_op);
			end else if (kind < 4) begin
				if (f3 == 3'd1) imm = {7'd0, word[4:0]};
				else if (f3 == 3'd5) imm = {1'b0, word[5], 5'd0, word[4:0]}; // SRLI or SRAI
				else imm = word[11:0];
				imem[8'(i)] = itype_word(imm, pick_rs(), f3, pick_rd(), opc_op_imm);
			end else if (kind < 7) begin
				f3 = 3'(rand_below(3));
				amask = f3[1] ? 6'h3c : (f3[0] ? 6'h3e : 6'h3f);
				imm = {6'd0, word[5:0] & amask};
				if (kind == 6) begin
					if (f3 != 3'd2 && word[8]) f3[2] = 1'b1; // LBU, LHU
					imem[8'(i)] = itype_word(imm, 5'd1, f3, pick_rd(), opc_load);
				end else begin
					imem[8'(i)] = stype_word(imm, pick_rs(), 5'd1, f3);
				end
			end else if (kind == 7) begin
				if (f3[2:1] == 2'b01) f3 = f3 ^ 3'b110;
				imem[8'(i)] = btype_word(13'((target - i) * 4), pick_rs(), pick_rs(), f3);
			end else if (kind == 8) begin
				imem[8'(i)] = jtype_word(21'((target - i) * 4), pick_rd());
			end else if (word[9] && i < program_len - 2) begin
				// AUIPC x7 then JALR off it
				target = i + 2 + rand_below(4);
				if (target > program_len - 1) target = program_len - 1;
				imem[8'(i)] = utype_word(20'd0, 5'd7, opc_auipc);
				imem[8'(i + 1)] = itype_word(12'((target - i) * 4), 5'd7, 3'd0, pick_rd(), opc_jalr);
				i = i + 1;
			end else begin
				imem[8'(i)] = utype_word(word[31:12], pick_rd(), word[10] ? opc_lui : opc_auipc);
			end
			i = i + 1;
		end
		imem[8'(program_len - 1)] = jtype_word(21'd0, 5'd0); // Jump to self
	endtask

	// Reference ISA run, fills the expected fetch and data queues
	task automatic run_model();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] word;
		logic [3:0]  strb;
		logic [2:0]  f3;
		logic        wr;
		int unsigned steps;
		mreg = '{default: 32'd0};
		for (int j = 0; j < 16; j++) begin
			mdmem[4'(j)] = fill_word(data_base + 32'(j * 4));
			dmem[4'(j)] = mdmem[4'(j)];
		end
		pc = reset_addr;
		steps = 0;
		while (steps < 1000) begin
			fetch_q.push_back(pc);
			ins = imem[instr_index(pc)];
			a = mreg[ins[19:15]];
			b = mreg[ins[24:20]];
			f3 = ins[14:12];
			addr = a + {{20{ins[31]}}, ins[31:20]};
			npc = pc + 32'd4;
			wr = 1'b1;
			val = 32'd0;
			case (ins[6:0])
				opc_op: val = alu_model(f3, ins[30], a, b);
				opc_op_imm: val = alu_model(f3, ins[30] && f3 == 3'd5, a, addr - a);
				opc_lui: val = {ins[31:12], 12'd0};
				opc_auipc: val = pc + {ins[31:12], 12'd0};
				opc_jal: begin
					val = pc + 32'd4;
					npc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				opc_jalr: begin
					val = pc + 32'd4;
					npc = addr & 32'hffff_fffe;
				end
				opc_branch: begin
					wr = 1'b0;
					if (branch_cond(f3, a, b)) begin
						npc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
					end
				end
				opc_load: begin
					val = load_extract(f3, addr[1:0], mdmem[data_index(addr)]);
					exp_daddr.push_back({addr[31:2], 2'b00});
					exp_dwrite.push_back(1'b0);
					exp_dstrb.push_back(4'd0);
					exp_dwdata.push_back(32'd0);
				end
				opc_store: begin
					wr = 1'b0;
					addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
					case (f3[1:0])
						2'b00: begin
							strb = 4'b0001 << addr[1:0];
							word = {4{b[7:0]}};
						end
						2'b01: begin
							strb = addr[1] ? 4'b1100 : 4'b0011;
							word = {2{b[15:0]}};
						end
						default: begin
							strb = 4'b1111;
							word = b;
						end
					endcase
					mdmem[data_index(addr)] = merge_bytes(mdmem[data_index(addr)], word, strb);
					exp_daddr.push_back({addr[31:2], 2'b00});
					exp_dwrite.push_back(1'b1);
					exp_dstrb.push_back(strb);
					exp_dwdata.push_back(word);
				end
				default: wr = 1'b0;
			endcase
			if (wr && ins[11:7] != 5'd0) mreg[ins[11:7]] = val;
			if (npc == pc) begin
				fetch_q.push_back(pc); // Repeated fetch ends the run
				break;
			end
			pc = npc;
			steps++;
		end
	endtask

	// Bus responders and checks
	always @(posedge clock) begin
		if (reset) begin
			iready <= 1'b0;
			dready <= 1'b0;
			if (ivalid || dvalid) begin
				err_reset++;
				$display("bus request raised while reset is high at %0t", $time);
			end
		end else begin
			if (!run_started) begin
				run_started = 1'b1;
				checks++;
				if (!ivalid || iaddr != reset_addr) begin
					err_reset++;
					$display("mismatch at %0t: first fetch ivalid %b iaddr %h, expected 1 and %h",
						$time, ivalid, iaddr, reset_addr);
				end
			end
			if (ivalid && iready) begin
				checks++;
				nfetch++;
				iready <= 1'b0;
				if (fetch_q.size() == 0) begin
					err_fetch++;
					$display("fetch beyond the end of the program at %0t", $time);
				end else begin
					expect_addr = fetch_q.pop_front();
					if (iaddr != expect_addr) begin
						err_fetch++;
						$display("mismatch at %0t: fetch address %h, expected %h",
							$time, iaddr, expect_addr);
					end
					if (fetch_q.size() == 0) done = 1'b1;
				end
			end else if (ivalid) begin
				iready <= (rand_below(3) != 0);
				idata  <= imem[instr_index(iaddr)];
			end else begin
				iready <= 1'b0;
			end
			if (dvalid && dready) begin
				checks++;
				ndata++;
				dready <= 1'b0;
				if (exp_daddr.size() == 0) begin
					err_data++;
					$display("data access with no matching load or store at %0t", $time);
				end else begin
					expect_addr  = exp_daddr.pop_front();
					expect_write = exp_dwrite.pop_front();
					expect_strb  = exp_dstrb.pop_front();
					expect_data  = exp_dwdata.pop_front();
					if (daddr != expect_addr || dwrite != expect_write) begin
						err_data++;
						$display("mismatch at %0t: data address %h write %b, expected %h write %b",
							$time, daddr, dwrite, expect_addr, expect_write);
					end else if (dwrite && (dstrb != expect_strb || dwdata != expect_data)) begin
						err_data++;
						$display("mismatch at %0t: store strobe %b data %h, expected %b data %h",
							$time, dstrb, dwdata, expect_strb, expect_data);
					end
				end
				if (dwrite) begin
					dmem[data_index(daddr)] =
						merge_bytes(dmem[data_index(daddr)], dwdata, dstrb);
				end
			end else if (dvalid) begin
				dready <= (rand_below(3) != 0);
				drdata <= dmem[data_index(daddr)];
			end else begin
				dready <= 1'b0;
			end
		end
	end

	initial begin
		iready = 1'b0;
		idata = 32'd0;
		dready = 1'b0;
		drdata = 32'd0;
		rng_state = seed;
		done = 1'b0;
		run_started = 1'b0;
		checks = 0;
		err_reset = 0;
		err_fetch = 0;
		err_data = 0;
		nfetch = 0;
		ndata = 0;
		build_program();
		run_model();
		wait (done);
		repeat (2) @(posedge clock);
		checks++;
		if (exp_daddr.size() != 0) begin
			err_data++;
			$display("%0d expected loads or stores never reached the data bus", exp_daddr.size());
		end
		$display("test reset_and_first_fetch: %0d errors", err_reset);
		$display("test fetch_sequence: %0d fetches, %0d errors", nfetch, err_fetch);
		$display("test data_accesses: %0d transfers, %0d errors", ndata, err_data);
		total = err_reset + err_fetch + err_data;
		$display("tests 3, checks %0d, errors %0d", checks, total);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Bounded by the worst case instruction length with stalls
	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog timeout: the core did not reach the end of the program");
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- build.f
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_comparator.sv
design/rv_regfile.sv
design/rv_load_store.sv
design/rv_core.sv
tb/rv_clock_gen.sv
tb/rv_core_tb.sv

//--- run.sh
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module rv_core_tb \
	-f build.f -o rv_core_sim &&
./obj_dir/rv_core_sim | tee sim.log &&
grep -q "Result: PASSED" sim.log || { echo "simulation failed"; exit 1; }
